//--- source/fifo_cfg.svh
// build-time sizing for the dual-clock FIFO
// pulled in by fifoPkg and by any module that needs the raw numbers
`ifndef FIFO_CFG_SVH
`define FIFO_CFG_SVH

//--------------------------------------------------
// storage geometry
//--------------------------------------------------
`define FIFO_DEPTH       256                  // words, power of two only
`define FIFO_DATA_WIDTH  24                   // one pixel / stream word
`define FIFO_ADDR_WIDTH  $clog2(`FIFO_DEPTH)  // ram address bits

//--------------------------------------------------
// flag tuning
//--------------------------------------------------
// full rises while free slots <= this margin
// covers the writer's own pipeline latency after it sees full
`define FIFO_ALMOST      6

`endif

//--- source/fifoPkg.sv
// shared types of the dual-clock FIFO
// import inside module bodies, scoped names in port lists
`include "fifo_cfg.svh"

package fifoPkg;

    //--------------------------------------------------
    // plain vectors
    //--------------------------------------------------
    // one stored word
    typedef logic [`FIFO_DATA_WIDTH-1:0] fifoData_t;

    // ram address, no wrap bit
    typedef logic [`FIFO_ADDR_WIDTH-1:0] fifoAddr_t;

    // pointer with extra wrap bit
    // same width for binary and gray forms
    typedef logic [`FIFO_ADDR_WIDTH:0]   fifoPtr_t;

    //--------------------------------------------------
    // bundles at the top-level boundary
    //--------------------------------------------------
    // write strobe plus its word, iSrcClk domain
    typedef struct packed
    {
        logic      en;    // push request
        fifoData_t data;  // word to store
    } wrReq_t;

    // read-out word and its pulse, iDstClk domain
    typedef struct packed
    {
        logic      valid; // one pulse per accepted read
        fifoData_t data;  // only meaningful with valid
    } rdBeat_t;

endpackage

//--- source/userFifoDual.sv
// simple dual-port ram behind the dual-clock FIFO
// write port on the source clock, registered read port on the destination clock
`timescale 1ns/10ps
`include "fifo_cfg.svh"

module userFifoDual (
    // write side
    input  logic                iSrcClk,
    input  logic                we,       // store wd at wa
    input  fifoPkg::fifoAddr_t  wa,
    input  fifoPkg::fifoData_t  wd,
    // read side
    input  logic                iDstClk,
    input  fifoPkg::fifoAddr_t  ra,       // sampled every edge
    output fifoPkg::fifoData_t  rd        // mem[ra] one cycle later
);
    import fifoPkg::*;

    //--------------------------------------------------
    // storage
    //--------------------------------------------------
    // plain array so synthesis maps it onto block ram
    fifoData_t mem [`FIFO_DEPTH];

    // read data register
    fifoData_t rdQ;

    //--------------------------------------------------
    // write port
    //--------------------------------------------------
    always_ff @(posedge iSrcClk)
    begin
        if (we)
        begin
            mem[wa] <= wd;  // controller already dropped writes while full
        end
    end

    //--------------------------------------------------
    // read port
    //--------------------------------------------------
    // free-running read, validity is tracked by the controller
    // the address is only ever one that the sync'd write pointer has passed
    // so no same-address collision with the write port
    always_ff @(posedge iDstClk)
    begin
        rdQ <= mem[ra];
    end

    assign rd = rdQ;  // output register of the bram

endmodule

//--- source/grayPtrSync.sv
// carries a FIFO pointer from one clock domain to the other
// binary in, gray across two flops, binary out; one instance per direction
`timescale 1ns/10ps

module grayPtrSync (
    // home domain of the pointer
    input  logic              srcClk,
    input  logic              srcReset,  // active high, sync to srcClk
    input  fifoPkg::fifoPtr_t binIn,     // steps by at most one per srcClk
    // receiving domain
    input  logic              dstClk,
    input  logic              dstReset,  // active high, sync to dstClk
    output fifoPkg::fifoPtr_t binOut     // lagging copy of binIn
);
    import fifoPkg::*;

    localparam int ptrWidth = $bits(fifoPtr_t);

    fifoPtr_t grayQ;     // source-domain gray register
    fifoPtr_t syncQ1;    // first flop, may go metastable
    fifoPtr_t syncQ2;    // settled gray value
    fifoPtr_t binQ;      // decoded result

    // prefix xor from the msb down
    function automatic fifoPtr_t grayToBin(input fifoPtr_t g);
        fifoPtr_t b;
        b[ptrWidth-1] = g[ptrWidth-1];
        for (int i = ptrWidth - 2; i >= 0; i--)
        begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    //--------------------------------------------------
    // source domain
    //--------------------------------------------------
    // registered so no combinational glitch ever leaves the domain
    always_ff @(posedge srcClk)
    begin
        if (srcReset)
            grayQ <= '0;
        else
            grayQ <= binIn ^ (binIn >> 1);  // bin -> gray
    end

    //--------------------------------------------------
    // destination domain
    //--------------------------------------------------
    always_ff @(posedge dstClk)
    begin
        if (dstReset)
        begin
            syncQ1 <= '0;
            syncQ2 <= '0;
            binQ   <= '0;
        end
        else
        begin
            syncQ1 <= grayQ;              // crossing point
            syncQ2 <= syncQ1;
            binQ   <= grayToBin(syncQ2);  // back to binary for the flag math
        end
    end

    assign binOut = binQ;

    // single-bit steps are what make the two-flop crossing safe
    // X before the first reset pulse is skipped by the disable
    assert property (@(posedge srcClk) disable iff (srcReset !== 1'b0)
        $countones(grayQ ^ $past(grayQ)) <= 1)
    else
        $error("gray pointer moved by more than one bit in one source cycle");

endmodule

//--- source/fifoDualController.sv
// pointer and flag logic of the dual-clock FIFO, owns the ram and both syncs
// writes on iSrcClk, reads on iDstClk, data comes back 2 cycles after a read
`timescale 1ns/10ps
`include "fifo_cfg.svh"

module fifoDualController (
    input  logic             iSrcClk,   // writer clock
    input  logic             iDstClk,   // reader clock
    input  logic             reset,     // sync active high, iDstClk domain
    // write side, iSrcClk
    input  fifoPkg::wrReq_t  wrReq,
    output logic             full,      // early by FIFO_ALMOST
    // read side, iDstClk
    input  logic             rdEn,
    output fifoPkg::rdBeat_t rdBeat,
    output logic             empty      // conservative
);
    import fifoPkg::*;

    // same width as the pointers so the modulo math stays 9 bit
    localparam fifoPtr_t depthPtr  = fifoPtr_t'(`FIFO_DEPTH);
    localparam fifoPtr_t fullLevel = fifoPtr_t'(`FIFO_DEPTH - `FIFO_ALMOST);

    // wrap-bit pointer scheme only works for 2^n depth
    if ((1 << `FIFO_ADDR_WIDTH) != `FIFO_DEPTH)
    begin : gDepthCheck
        $error("FIFO_DEPTH must be a power of two");
    end
    if (`FIFO_ALMOST >= `FIFO_DEPTH)
    begin : gAlmostCheck
        $error("FIFO_ALMOST must be smaller than FIFO_DEPTH");
    end

    //--------------------------------------------------
    // source-side reset
    //--------------------------------------------------
    logic [1:0] srcRstPipe;   // reset re-timed into iSrcClk
    logic       srcReset;

    always_ff @(posedge iSrcClk)
    begin
        srcRstPipe <= {srcRstPipe[0], reset};
    end

    assign srcReset = srcRstPipe[1];

    //--------------------------------------------------
    // write side
    //--------------------------------------------------
    fifoPtr_t wrPtr;        // next slot to fill
    fifoPtr_t wrPtrNext;
    fifoPtr_t rdPtrSrc;     // read pointer as seen by the writer
    fifoPtr_t fillNext;     // words held after this edge, pessimistic
    logic     wrAccept;

    assign wrAccept  = wrReq.en & ~full;        // drop while full
    assign wrPtrNext = wrPtr + fifoPtr_t'(wrAccept);
    assign fillNext  = wrPtrNext - rdPtrSrc;    // wraps cleanly via extra bit

    always_ff @(posedge iSrcClk)
    begin
        if (srcReset)
        begin
            wrPtr <= '0;
            full  <= 1'b0;
        end
        else
        begin
            wrPtr <= wrPtrNext;
            full  <= (fillNext >= fullLevel);   // free slots <= FIFO_ALMOST
        end
    end

    //--------------------------------------------------
    // read side
    //--------------------------------------------------
    fifoPtr_t   rdPtr;      // next word to hand out
    fifoPtr_t   rdPtrNext;
    fifoPtr_t   wrPtrDst;   // write pointer as seen by the reader
    fifoAddr_t  rdAddr;     // word consumed by the last accepted read
    fifoData_t  ramRd;      // ram output register
    logic       rdAccept;
    logic [1:0] vldPipe;    // read strobe delayed to line up with ramRd

    assign rdAccept  = rdEn & ~empty;           // ignore reads while empty
    assign rdPtrNext = rdPtr + fifoPtr_t'(rdAccept);

    always_ff @(posedge iDstClk)
    begin
        if (reset)
        begin
            rdPtr   <= '0;
            empty   <= 1'b1;
            vldPipe <= '0;
        end
        else
        begin
            rdPtr   <= rdPtrNext;
            // includes a read taken at this edge so the last word is not reread
            empty   <= (wrPtrDst == rdPtrNext);
            vldPipe <= {vldPipe[0], rdAccept};
        end
    end

    // address of the word taken at this edge, ram latches it on the next
    always_ff @(posedge iDstClk)
    begin
        if (rdAccept)
        begin
            rdAddr <= rdPtr[`FIFO_ADDR_WIDTH-1:0];
        end
    end

    assign rdBeat = '{valid: vldPipe[1], data: ramRd};

    //--------------------------------------------------
    // storage and crossings
    //--------------------------------------------------
    userFifoDual fifoRam (
        .iSrcClk (iSrcClk),
        .we      (wrAccept),
        .wa      (wrPtr[`FIFO_ADDR_WIDTH-1:0]),
        .wd      (wrReq.data),
        .iDstClk (iDstClk),
        .ra      (rdAddr),
        .rd      (ramRd)
    );

    // write pointer into the reader domain, feeds empty
    grayPtrSync wrPtrSync (
        .srcClk   (iSrcClk),
        .srcReset (srcReset),
        .binIn    (wrPtr),
        .dstClk   (iDstClk),
        .dstReset (reset),
        .binOut   (wrPtrDst)
    );

    // read pointer into the writer domain, feeds full
    grayPtrSync rdPtrSync (
        .srcClk   (iDstClk),
        .srcReset (reset),
        .binIn    (rdPtr),
        .dstClk   (iSrcClk),
        .dstReset (srcReset),
        .binOut   (rdPtrSrc)
    );

    //--------------------------------------------------
    // pointer sanity
    //--------------------------------------------------
    // reader never overtakes what the writer has published
    assert property (@(posedge iDstClk) disable iff (reset !== 1'b0)
        fifoPtr_t'(wrPtrDst - rdPtr) <= depthPtr)
    else
        $error("read pointer %h passed synced write pointer %h", rdPtr, wrPtrDst);

    // writer never laps the reader it can see
    assert property (@(posedge iSrcClk) disable iff (srcReset !== 1'b0)
        fifoPtr_t'(wrPtr - rdPtrSrc) <= depthPtr)
    else
        $error("write pointer %h ran past depth ahead of %h", wrPtr, rdPtrSrc);

endmodule

//--- source/fifoDualTop.sv
// drop-in dual-clock FIFO for a stream or video datapath
// writer watches full on iSrcClk, reader gets rdBeat two iDstClk cycles after rdEn
`timescale 1ns/10ps

module fifoDualTop (
    //--------------------------------------------------
    // clocks and reset
    //--------------------------------------------------
    input  logic             iSrcClk,   // writer domain
    input  logic             iDstClk,   // reader domain
    input  logic             reset,     // sync active high on iDstClk

    //--------------------------------------------------
    // writer, iSrcClk domain
    //--------------------------------------------------
    // word stored when wrReq.en and not full
    input  fifoPkg::wrReq_t  wrReq,
    output logic             full,      // back-pressure, FIFO_ALMOST early

    //--------------------------------------------------
    // reader, iDstClk domain
    //--------------------------------------------------
    // read taken when rdEn and not empty
    input  logic             rdEn,
    output fifoPkg::rdBeat_t rdBeat,    // valid pulse plus word
    output logic             empty      // may lag a write by a few cycles
);

    // all logic sits in the controller
    // this level only fixes the boundary a parent design sees
    fifoDualController fifoCtrl (
        .iSrcClk (iSrcClk),
        .iDstClk (iDstClk),
        .reset   (reset),
        // write side
        .wrReq   (wrReq),
        .full    (full),
        // read side
        .rdEn    (rdEn),
        .rdBeat  (rdBeat),
        .empty   (empty)
    );

endmodule

//--- tests/fifoDualTb.sv
// testbench for the dual-clock FIFO, random writer and reader against a reference queue
// concurrent assertions do the checking, the run ends with one error summary line
`timescale 1ns/10ps
`include "fifo_cfg.svh"

module fifoDualTb;
    import fifoPkg::*;

    //--------------------------------------------------
    // run constants
    //--------------------------------------------------
    localparam real dstHalf       = 4.0;   // 8 ns reader clock
    localparam real srcHalf       = 5.5;   // 11 ns writer clock, drifts against dst
    localparam int  dstPeriod     = 8;
    localparam int  resetCycles   = 16;
    localparam int  extraWrites   = 24;    // attempts offered into a full FIFO
    localparam int  idleReads     = 24;    // reads offered while empty
    localparam int  segCycles     = 800;   // mixed phase, one read-rate segment
    localparam int  mixedCycles   = 6 * segCycles;
    localparam int  plannedCycles = 10 * `FIFO_DEPTH + mixedCycles;
    localparam int  wdCycles      = plannedCycles + 2000;

    // phases of the run
    localparam int phIdle  = 0;
    localparam int phBurst = 1;   // writes only, until full
    localparam int phDrain = 2;   // reads only, until empty
    localparam int phMixed = 3;
    localparam int phFlush = 4;   // reads only, pick up what is left

    //--------------------------------------------------
    // DUT signals
    //--------------------------------------------------
    logic    iSrcClk = 1'b0;
    logic    iDstClk = 1'b0;
    logic    reset;
    wrReq_t  wrReq;
    logic    full;
    logic    rdEn;
    rdBeat_t rdBeat;
    logic    empty;

    //--------------------------------------------------
    // stimulus and reference state
    //--------------------------------------------------
    integer    seed;          // writer stream
    integer    rdSeed;        // reader stream, own copy so clock phase does not matter
    int        phase;
    logic      armed;         // both reset copies released
    logic      firstPush;
    logic      readHeavy;     // mixed phase read rate

    fifoData_t refQ[$];       // words written and not yet seen on rdBeat
    fifoData_t frontWord;
    logic      frontValid;
    int        queueSize;
    int        pushCount;
    int        readsTaken;    // accepted reads
    int        beatCount;

    int        latencyErrors;
    int        dataErrors;
    int        flagErrors;
    int        orderErrors;
    int        totalErrors;

    always #(dstHalf) iDstClk = ~iDstClk;
    always #(srcHalf) iSrcClk = ~iSrcClk;

    fifoDualTop UUT (
        .iSrcClk (iSrcClk),
        .iDstClk (iDstClk),
        .reset   (reset),
        .wrReq   (wrReq),
        .full    (full),
        .rdEn    (rdEn),
        .rdBeat  (rdBeat),
        .empty   (empty)
    );

    // mirror of the queue head, read by the assertions
    task automatic refreshModel();
        queueSize  = refQ.size();
        frontValid = (queueSize > 0);
        frontWord  = frontValid ? refQ[0] : '0;
    endtask

    task automatic waitForFull();
        while (full !== 1'b1)
        begin
            @(posedge iSrcClk);
            #1;
        end
    endtask

    // model empty and DUT empty both
    task automatic waitForDrained();
        while (!(queueSize == 0 && empty === 1'b1))
        begin
            @(posedge iDstClk);
            #1;
        end
    endtask

    //--------------------------------------------------
    // reference model
    //--------------------------------------------------
    always @(posedge iSrcClk)
    begin
        if (armed && wrReq.en && full === 1'b0)   // same accept rule as the writer port
        begin
            refQ.push_back(wrReq.data);
            pushCount++;
            firstPush = 1'b1;
            refreshModel();
        end
    end

    always @(posedge iDstClk)
    begin
        if (!reset)
        begin
            if (rdEn && empty === 1'b0)
                readsTaken++;
            if (rdBeat.valid === 1'b1)
            begin
                beatCount++;
                if (refQ.size() > 0)
                    void'(refQ.pop_front());   // aBeatHasWord flags the empty case
                refreshModel();
            end
        end
    end

    //--------------------------------------------------
    // drivers, 1 ns after their own edge
    //--------------------------------------------------
    initial
    begin
        forever
        begin
            @(posedge iSrcClk);
            #1;
            case (phase)
                phBurst: wrReq.en = 1'b1;                      // keeps pushing into full
                phMixed: wrReq.en = ($random(seed) & 3) != 0;  // 3 of 4 cycles
                default: wrReq.en = 1'b0;
            endcase
            wrReq.data = wrReq.en ? fifoData_t'($random(seed)) : '0;
        end
    end

    initial
    begin
        forever
        begin
            @(posedge iDstClk);
            #1;
            case (phase)
                phDrain: rdEn = ($random(rdSeed) & 7) != 0;
                phMixed:
                    if (readHeavy)
                        rdEn = ($random(rdSeed) & 7) != 0;   // outruns the writer
                    else
                        rdEn = ($random(rdSeed) & 7) == 0;   // writer fills up
                phFlush: rdEn = 1'b1;
                default: rdEn = 1'b0;
            endcase
        end
    end

    //--------------------------------------------------
    // checks
    //--------------------------------------------------
    // reset state until the first word goes in
    aResetDst: assert property (@(posedge iDstClk) disable iff (reset)
        !firstPush |-> (empty && !rdBeat.valid))
    else
    begin
        flagErrors++;
        $display("Error: empty=%h rdBeat.valid=%h before first write, expected 1 and 0",
                 $sampled(empty), $sampled(rdBeat.valid));
    end

    aResetSrc: assert property (@(posedge iSrcClk) disable iff (reset)
        (armed && !firstPush) |-> !full)
    else
    begin
        flagErrors++;
        $display("Error: full=%h before first write, expected 0", $sampled(full));
    end

    aLatency: assert property (@(posedge iDstClk) disable iff (reset)
        (rdEn && !empty) |-> ##2 rdBeat.valid)
    else
    begin
        latencyErrors++;
        $display("Error: rdBeat.valid=%h two cycles after a read, expected 1",
                 $sampled(rdBeat.valid));
    end

    aNoSpurious: assert property (@(posedge iDstClk) disable iff (reset)
        rdBeat.valid |-> $past(rdEn && !empty, 2))
    else
    begin
        latencyErrors++;
        $display("Error: rdBeat.valid=%h with no accepted read two cycles before",
                 $sampled(rdBeat.valid));
    end

    aBeatHasWord: assert property (@(posedge iDstClk) disable iff (reset)
        rdBeat.valid |-> frontValid)
    else
    begin
        orderErrors++;
        $display("read beat arrived while the reference queue was empty");
    end

    aDataMatch: assert property (@(posedge iDstClk) disable iff (reset)
        (rdBeat.valid && frontValid) |-> (rdBeat.data == frontWord))
    else
    begin
        dataErrors++;
        $display("Error: rdBeat.data=%h expected %h", $sampled(rdBeat.data),
                 $sampled(frontWord));
    end

    // a read can only be taken once a written word got across
    aNoUnderrun: assert property (@(posedge iDstClk) disable iff (reset)
        (rdEn && !empty) |-> (readsTaken < pushCount))
    else
    begin
        orderErrors++;
        $display("read accepted with no written word left to hand out");
    end

    // full must stop the writer short of the depth
    aFullBound: assert property (@(posedge iSrcClk) disable iff (reset)
        armed |-> (queueSize < `FIFO_DEPTH))
    else
    begin
        flagErrors++;
        $display("reference queue reached %0d words and full did not hold the writer back",
                 $sampled(queueSize));
    end

    aEmptyDrained: assert property (@(posedge iDstClk) disable iff (reset)
        ((phase == phDrain || phase == phFlush) && queueSize == 0) |-> empty)
    else
    begin
        flagErrors++;
        $display("Error: empty=%h with all words read, expected 1", $sampled(empty));
    end

    //--------------------------------------------------
    // watchdog
    //--------------------------------------------------
    initial
    begin
        #(wdCycles * dstPeriod);
        $display("timeout: run did not finish within %0d reader clock cycles", wdCycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    //--------------------------------------------------
    // main sequence
    //--------------------------------------------------
    initial
    begin
        seed          = 32'ha5ab;
        rdSeed        = seed ^ 32'h0000_5a5a;
        reset         = 1'b1;
        wrReq         = '0;
        rdEn          = 1'b0;
        phase         = phIdle;
        armed         = 1'b0;
        firstPush     = 1'b0;
        readHeavy     = 1'b0;
        pushCount     = 0;
        readsTaken    = 0;
        beatCount     = 0;
        latencyErrors = 0;
        dataErrors    = 0;
        flagErrors    = 0;
        orderErrors   = 0;
        refreshModel();

        repeat (resetCycles) @(posedge iDstClk);
        #1;
        reset = 1'b0;
        repeat (4) @(posedge iSrcClk);   // source copy of reset trails by two src edges
        armed = 1'b1;

        // write-only burst, then keep offering words into full
        phase = phBurst;
        waitForFull();
        repeat (extraWrites) @(posedge iSrcClk);

        // read everything back, then poke an empty FIFO
        phase = phDrain;
        waitForDrained();
        repeat (idleReads) @(posedge iDstClk);

        // alternating slow and fast reader, reaches both flags
        phase = phMixed;
        for (int seg = 0; seg < mixedCycles / segCycles; seg++)
        begin
            readHeavy = seg[0];
            repeat (segCycles) @(posedge iDstClk);
        end

        phase = phFlush;
        repeat (8) @(posedge iDstClk);   // last writes still crossing
        waitForDrained();
        repeat (8) @(posedge iDstClk);
        phase = phIdle;

        assert (refQ.size() == 0 && readsTaken == pushCount && beatCount == pushCount)
        else
        begin
            orderErrors++;
            $display("words lost or duplicated: %0d written, %0d read, %0d beats, %0d left",
                     pushCount, readsTaken, beatCount, refQ.size());
        end

        totalErrors = latencyErrors + dataErrors + flagErrors + orderErrors;
        $display("errors: latency %0d, data %0d, flags %0d, order %0d (%0d words moved)",
                 latencyErrors, dataErrors, flagErrors, orderErrors, beatCount);
        if (totalErrors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- build.f
+incdir+source
source/fifoPkg.sv
source/userFifoDual.sv
source/grayPtrSync.sv
source/fifoDualController.sv
source/fifoDualTop.sv
tests/fifoDualTb.sv

//--- Bender.yml
package:
  name: fifo_dual

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/fifoPkg.sv
      - source/userFifoDual.sv
      - source/grayPtrSync.sv
      - source/fifoDualController.sv
      - source/fifoDualTop.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/fifoDualTb.sv
